/* Makefile */
# Verilator flow for the image input pipe
VERILATOR  ?= verilator
TOP        ?= tb_image_pipe
RTL_TOP    ?= image_pipe_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
+incdir+hdl
+incdir+sim
hdl/image_pipe_pkg.sv
hdl/axis_dw_image_input.sv
hdl/axis_image_pipe.sv
hdl/axis_out_slice.sv
hdl/image_pipe_top.sv
sim/tb_image_pipe.sv

/* hdl/axis_dw_image_input.sv */
`timescale 1ns/1ps
`include "image_pipe_config.svh"

module axis_dw_image_input #(
  parameter int IN_WORDS  = `IP_IN_WORDS,
  parameter int OUT_WORDS = `IP_UNITS_EDGES
) (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      s_tvalid,
  output logic                      s_tready,
  input  image_pipe_pkg::in_data_t  s_tdata,
  input  image_pipe_pkg::in_keep_t  s_tkeep,
  input  logic                      s_tlast,
  output logic                      m_tvalid,
  input  logic                      m_tready,
  output image_pipe_pkg::edge_data_t m_tdata,
  output logic                      m_tlast
);

  localparam int WORD_W    = $bits(image_pipe_pkg::word_t);
  localparam int BUF_WORDS = 2 * IN_WORDS;
  localparam int FILL_W    = $clog2(BUF_WORDS + 1);

  logic [BUF_WORDS-1:0][WORD_W-1:0] byte_buf, byte_buf_next;
  logic [FILL_W-1:0] fill, fill_next;
  logic [FILL_W-1:0] pos;          // write slot while packing
  logic              last_pending; // tlast seen, remainder not yet sent
  logic              in_hs, out_hs;

  assign in_hs  = s_tvalid && s_tready;
  assign out_hs = m_tvalid && m_tready;

  // no new packet bytes until the previous one has flushed
  assign s_tready = !last_pending && (fill <= FILL_W'(BUF_WORDS - IN_WORDS));

  assign m_tvalid = (fill >= FILL_W'(OUT_WORDS)) || (last_pending && fill != '0);
  assign m_tlast  = last_pending && (fill <= FILL_W'(OUT_WORDS));

  // bytes above the fill level read as zero, pads the final beat
  always_comb begin
    for (int j = 0; j < OUT_WORDS; j++) begin
      m_tdata[j*WORD_W +: WORD_W] = (j < fill) ? byte_buf[j] : '0;
    end
  end

  // drop the sent beat first, then append the kept input bytes
  always_comb begin
    byte_buf_next = byte_buf;
    pos           = fill;
    if (out_hs) begin
      byte_buf_next = byte_buf >> (OUT_WORDS * WORD_W);
      pos = (fill > FILL_W'(OUT_WORDS)) ? fill - FILL_W'(OUT_WORDS) : '0;
    end
    if (in_hs) begin
      for (int i = 0; i < IN_WORDS; i++) begin
        if (s_tkeep[i]) begin
          byte_buf_next[pos] = s_tdata[i*WORD_W +: WORD_W];
          pos = pos + 1'b1;
        end
      end
    end
    fill_next = pos;
  end

  always_ff @(posedge aclk) begin
    byte_buf <= byte_buf_next;
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      fill         <= '0;
      last_pending <= 1'b0;
    end else begin
      fill <= fill_next;
      if (in_hs && s_tlast) begin
        last_pending <= 1'b1;
      end else if (out_hs && m_tlast) begin
        last_pending <= 1'b0;
      end else if (last_pending && fill == '0) begin
        last_pending <= 1'b0; // empty last beat, nothing left to send
      end
    end
  end

endmodule

/* hdl/axis_image_pipe.sv */
`timescale 1ns/1ps
`include "image_pipe_config.svh"

module axis_image_pipe (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic                       s1_valid,
  output logic                       s1_ready,
  input  image_pipe_pkg::edge_data_t s1_data,
  input  logic                       s1_last,
  input  logic                       s2_valid,
  output logic                       s2_ready,
  input  image_pipe_pkg::edge_data_t s2_data,
  input  logic                       s2_last,
  output logic                       m_valid,
  input  logic                       m_ready,
  output image_pipe_pkg::out_data_t  m_data,
  output image_pipe_pkg::kernel_h_t  m_user,
  output logic                       m_last
);

  localparam int WORD_W = $bits(image_pipe_pkg::word_t);
  localparam int KH_W   = $bits(image_pipe_pkg::kernel_h_t);

  image_pipe_pkg::pipe_state_e state;
  image_pipe_pkg::beat_count_t ones_count;
  image_pipe_pkg::beat_count_t ones_last;  // index of the final ones beat
  image_pipe_pkg::kernel_h_t   kernel_h_1;
  logic                        is_max;
  logic                        s1_hs, m_hs;

  assign s1_hs = s1_valid && s1_ready;
  assign m_hs  = m_valid && m_ready;

  assign ones_last = (kernel_h_1 == '0) ?
                     image_pipe_pkg::beat_count_t'(`IP_BEATS_CONFIG_1X1 - 1) :
                     image_pipe_pkg::beat_count_t'(`IP_BEATS_CONFIG_3X3 - 1);

  // handshake steering per state
  always_comb begin
    case (state)
      image_pipe_pkg::SET_S: begin
        m_valid  = 1'b0;
        s1_ready = 1'b1; // config beat is consumed here
        s2_ready = 1'b0;
      end
      image_pipe_pkg::ONES_S: begin
        m_valid  = 1'b1;
        s1_ready = 1'b0;
        s2_ready = 1'b0;
      end
      default: begin
        // max mode moves both streams in lockstep
        m_valid  = is_max ? (s1_valid && s2_valid) : s1_valid;
        s1_ready = is_max ? (m_ready && s2_valid) : m_ready;
        s2_ready = is_max ? (m_ready && s1_valid) : 1'b0;
      end
    endcase
  end

  always_comb begin
    if (state == image_pipe_pkg::ONES_S) begin
      m_data = '1;
    end else begin
      m_data = {(is_max ? s2_data : s1_data), s1_data};
    end
  end

  assign m_user = kernel_h_1;
  assign m_last = (state == image_pipe_pkg::PASS_S) && s1_last;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= image_pipe_pkg::SET_S;
      ones_count <= '0;
      is_max     <= 1'b0;
      kernel_h_1 <= '0;
    end else begin
      case (state)
        image_pipe_pkg::SET_S: begin
          if (s1_hs) begin
            is_max     <= s1_data[0];                // byte 0 bit 0
            kernel_h_1 <= s1_data[WORD_W +: KH_W];   // byte 1
            state      <= image_pipe_pkg::ONES_S;
          end
        end
        image_pipe_pkg::ONES_S: begin
          if (m_hs) begin
            if (ones_count == ones_last) begin
              ones_count <= '0;
              state      <= image_pipe_pkg::PASS_S;
            end else begin
              ones_count <= ones_count + 1'b1;
            end
          end
        end
        default: begin
          if (s1_hs && s1_last) begin
            state <= image_pipe_pkg::SET_S; // image done, expect a new config
          end
        end
      endcase
    end
  end

endmodule

/* hdl/axis_out_slice.sv */
`timescale 1ns/1ps

module axis_out_slice (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      s_valid,
  output logic                      s_ready,
  input  image_pipe_pkg::out_data_t s_data,
  input  image_pipe_pkg::kernel_h_t s_user,
  input  logic                      s_last,
  output logic                      m_valid,
  input  logic                      m_ready,
  output image_pipe_pkg::out_data_t m_data,
  output image_pipe_pkg::kernel_h_t m_user,
  output logic                      m_last
);

  image_pipe_pkg::out_data_t skid_data;
  image_pipe_pkg::kernel_h_t skid_user;
  logic                      skid_last;
  logic                      skid_valid;
  logic                      main_load;

  assign s_ready   = !skid_valid;           // purely from a flop
  assign main_load = !m_valid || m_ready;   // main is free this cycle

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      m_valid    <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (s_valid && s_ready) begin
      skid_valid <= 1'b1; // main stalled, park the beat
    end
  end

  // skid follows the input while empty
  always_ff @(posedge aclk) begin
    if (s_ready) begin
      skid_data <= s_data;
      skid_user <= s_user;
      skid_last <= s_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_load) begin
      m_data <= skid_valid ? skid_data : s_data;
      m_user <= skid_valid ? skid_user : s_user;
      m_last <= skid_valid ? skid_last : s_last;
    end
  end

endmodule

/* hdl/image_pipe_config.svh */
`ifndef IMAGE_PIPE_CONFIG_SVH
`define IMAGE_PIPE_CONFIG_SVH

// conv units fed per output half
`define IP_UNITS            4
`define IP_WORD_WIDTH       8   // pixel bits
`define IP_KERNEL_H_MAX     3   // odd

// units plus the kernel border rows
`define IP_UNITS_EDGES      (`IP_UNITS + `IP_KERNEL_H_MAX - 1)
`define IP_IN_WORDS         8   // bytes per dma beat

`define IP_KERNEL_H_BITS    2   // holds kernel_h_1
`define IP_BEAT_COUNT_BITS  5   // holds the longest ones burst

// activation config preload, beats per kernel size
`define IP_BEATS_CONFIG_1X1 13
`define IP_BEATS_CONFIG_3X3 21

`endif

/* hdl/image_pipe_pkg.sv */
`include "image_pipe_config.svh"

package image_pipe_pkg;

  typedef logic [`IP_WORD_WIDTH-1:0] word_t;

  // dma side beat and its byte enables
  typedef logic [`IP_IN_WORDS*`IP_WORD_WIDTH-1:0] in_data_t;
  typedef logic [`IP_IN_WORDS-1:0]                in_keep_t;

  typedef logic [`IP_UNITS_EDGES*`IP_WORD_WIDTH-1:0]   edge_data_t;  // one converter beat
  typedef logic [2*`IP_UNITS_EDGES*`IP_WORD_WIDTH-1:0] out_data_t;   // low half at bit 0

  typedef logic [`IP_KERNEL_H_BITS-1:0]   kernel_h_t;
  typedef logic [`IP_BEAT_COUNT_BITS-1:0] beat_count_t;

  // per image sequence of the pipe
  typedef enum logic [1:0] {
    SET_S,   // waiting for the config beat
    ONES_S,  // activation config burst
    PASS_S   // pixel data
  } pipe_state_e;

endpackage

/* hdl/image_pipe_top.sv */
`timescale 1ns/1ps

module image_pipe_top (
  input  logic                      aclk,
  input  logic                      rst_n,
  input  logic                      s_axis_1_tvalid,
  output logic                      s_axis_1_tready,
  input  image_pipe_pkg::in_data_t  s_axis_1_tdata,
  input  image_pipe_pkg::in_keep_t  s_axis_1_tkeep,
  input  logic                      s_axis_1_tlast,
  input  logic                      s_axis_2_tvalid,
  output logic                      s_axis_2_tready,
  input  image_pipe_pkg::in_data_t  s_axis_2_tdata,
  input  image_pipe_pkg::in_keep_t  s_axis_2_tkeep,
  input  logic                      s_axis_2_tlast,
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output image_pipe_pkg::out_data_t m_axis_tdata,
  output image_pipe_pkg::kernel_h_t m_axis_tuser,
  output logic                      m_axis_tlast
);

  // converter outputs
  logic                       dw1_valid, dw1_ready, dw1_last;
  image_pipe_pkg::edge_data_t dw1_data;
  logic                       dw2_valid, dw2_ready, dw2_last;
  image_pipe_pkg::edge_data_t dw2_data;

  // pipe to output slice
  logic                       pipe_valid, pipe_ready, pipe_last;
  image_pipe_pkg::out_data_t  pipe_data;
  image_pipe_pkg::kernel_h_t  pipe_user;

  axis_dw_image_input dw_1 (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_tvalid (s_axis_1_tvalid),
    .s_tready (s_axis_1_tready),
    .s_tdata  (s_axis_1_tdata),
    .s_tkeep  (s_axis_1_tkeep),
    .s_tlast  (s_axis_1_tlast),
    .m_tvalid (dw1_valid),
    .m_tready (dw1_ready),
    .m_tdata  (dw1_data),
    .m_tlast  (dw1_last)
  );

  axis_dw_image_input dw_2 (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s_tvalid (s_axis_2_tvalid),
    .s_tready (s_axis_2_tready),
    .s_tdata  (s_axis_2_tdata),
    .s_tkeep  (s_axis_2_tkeep),
    .s_tlast  (s_axis_2_tlast),
    .m_tvalid (dw2_valid),
    .m_tready (dw2_ready),
    .m_tdata  (dw2_data),
    .m_tlast  (dw2_last)
  );

  axis_image_pipe pipe (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .s1_valid (dw1_valid),
    .s1_ready (dw1_ready),
    .s1_data  (dw1_data),
    .s1_last  (dw1_last),
    .s2_valid (dw2_valid),
    .s2_ready (dw2_ready),
    .s2_data  (dw2_data),
    .s2_last  (dw2_last),
    .m_valid  (pipe_valid),
    .m_ready  (pipe_ready),
    .m_data   (pipe_data),
    .m_user   (pipe_user),
    .m_last   (pipe_last)
  );

  axis_out_slice slice (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (pipe_valid),
    .s_ready (pipe_ready),
    .s_data  (pipe_data),
    .s_user  (pipe_user),
    .s_last  (pipe_last),
    .m_valid (m_axis_tvalid),
    .m_ready (m_axis_tready),
    .m_data  (m_axis_tdata),
    .m_user  (m_axis_tuser),
    .m_last  (m_axis_tlast)
  );

endmodule

/* sim/tb_image_pipe_tasks.svh */
`ifndef TB_IMAGE_PIPE_TASKS_SVH
`define TB_IMAGE_PIPE_TASKS_SVH

// holds the beat until the converter takes it
task automatic send_beat_1(input image_pipe_pkg::in_data_t data,
                           input image_pipe_pkg::in_keep_t keep, input logic last);
  int   cycles = 0;
  logic hs     = 1'b0;
  s_axis_1_tvalid = 1'b1;
  s_axis_1_tdata  = data;
  s_axis_1_tkeep  = keep;
  s_axis_1_tlast  = last;
  while (!hs && !timed_out && cycles < TIMEOUT_CYCLES) begin
    #(CLK_PERIOD/4);  // tready settles in the low phase
    hs = s_axis_1_tready;
    @(negedge aclk);
    cycles++;
  end
  if (!hs && !timed_out) report_timeout("s_axis_1_tready");
endtask

task automatic send_beat_2(input image_pipe_pkg::in_data_t data,
                           input image_pipe_pkg::in_keep_t keep, input logic last);
  int   cycles = 0;
  logic hs     = 1'b0;
  s_axis_2_tvalid = 1'b1;
  s_axis_2_tdata  = data;
  s_axis_2_tkeep  = keep;
  s_axis_2_tlast  = last;
  while (!hs && !timed_out && cycles < TIMEOUT_CYCLES) begin
    #(CLK_PERIOD/4);
    hs = s_axis_2_tready;
    @(negedge aclk);
    cycles++;
  end
  if (!hs && !timed_out) report_timeout("s_axis_2_tready");
endtask

// up to a few idle cycles before each beat
task automatic drive_stream_1(input int gap_pct);
  for (int i = 0; i < data_1_q.size() && !timed_out; i++) begin
    for (int g = 0; g < 4 && $urandom_range(99) < gap_pct; g++) begin
      s_axis_1_tvalid = 1'b0;
      @(negedge aclk);
    end
    send_beat_1(data_1_q[i], keep_1_q[i], last_1_q[i]);
  end
  s_axis_1_tvalid = 1'b0;
endtask

task automatic drive_stream_2(input int gap_pct);
  for (int i = 0; i < data_2_q.size() && !timed_out; i++) begin
    for (int g = 0; g < 4 && $urandom_range(99) < gap_pct; g++) begin
      s_axis_2_tvalid = 1'b0;
      @(negedge aclk);
    end
    send_beat_2(data_2_q[i], keep_2_q[i], last_2_q[i]);
  end
  s_axis_2_tvalid = 1'b0;
endtask

task automatic recv_beat(input int bp_pct, output image_pipe_pkg::out_data_t data,
                         output image_pipe_pkg::kernel_h_t user, output logic last);
  int   cycles = 0;
  logic got    = 1'b0;
  while (!got && !timed_out && cycles < TIMEOUT_CYCLES) begin
    m_axis_tready = ($urandom_range(99) >= bp_pct);
    #(CLK_PERIOD/4);
    got  = m_axis_tvalid && m_axis_tready;
    data = m_axis_tdata;
    user = m_axis_tuser;
    last = m_axis_tlast;
    @(negedge aclk);
    cycles++;
  end
  if (!got && !timed_out) report_timeout("a beat on m_axis");
endtask

task automatic check_data(input string name, input image_pipe_pkg::out_data_t exp,
                          input image_pipe_pkg::out_data_t act);
  if (act !== exp) begin
    $display("[ERROR] %s expected %h got %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_user(input string name, input image_pipe_pkg::kernel_h_t exp,
                          input image_pipe_pkg::kernel_h_t act);
  if (act !== exp) begin
    $display("[ERROR] %s expected %h got %h", name, exp, act);
    errors++;
  end
endtask

task automatic check_last(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("[ERROR] %s expected %h got %h", name, exp, act);
    errors++;
  end
endtask

// takes as many beats as the model expects and then frees the output
task automatic collect_image(input int bp_pct);
  image_pipe_pkg::out_data_t data;
  image_pipe_pkg::kernel_h_t user;
  logic                      last;
  for (int i = 0; i < exp_data.size() && !timed_out; i++) begin
    recv_beat(bp_pct, data, user, last);
    if (!timed_out) begin
      check_data($sformatf("m_axis_tdata[%0d]", i), exp_data[i], data);
      check_user($sformatf("m_axis_tuser[%0d]", i), exp_user[i], user);
      check_last($sformatf("m_axis_tlast[%0d]", i), exp_last[i], last);
    end
  end
  m_axis_tready = 1'b1;
endtask

`endif

/* sim/tb_image_pipe.sv */
`timescale 1ns/1ps
`include "image_pipe_config.svh"

module tb_image_pipe;

  localparam int CLK_PERIOD     = 40;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int IN_WORDS       = `IP_IN_WORDS;
  localparam int WORD_W         = `IP_WORD_WIDTH;
  localparam int EDGES          = `IP_UNITS_EDGES;

  logic                      aclk;
  logic                      rst_n;
  logic                      s_axis_1_tvalid, s_axis_1_tready, s_axis_1_tlast;
  image_pipe_pkg::in_data_t  s_axis_1_tdata;
  image_pipe_pkg::in_keep_t  s_axis_1_tkeep;
  logic                      s_axis_2_tvalid, s_axis_2_tready, s_axis_2_tlast;
  image_pipe_pkg::in_data_t  s_axis_2_tdata;
  image_pipe_pkg::in_keep_t  s_axis_2_tkeep;
  logic                      m_axis_tvalid, m_axis_tready, m_axis_tlast;
  image_pipe_pkg::out_data_t m_axis_tdata;
  image_pipe_pkg::kernel_h_t m_axis_tuser;

  // input beats per stream
  image_pipe_pkg::in_data_t   data_1_q[$], data_2_q[$];
  image_pipe_pkg::in_keep_t   keep_1_q[$], keep_2_q[$];
  logic                       last_1_q[$], last_2_q[$];
  image_pipe_pkg::word_t      pix_1[$], pix_2[$];      // pixel bytes in order
  image_pipe_pkg::edge_data_t words_1[$], words_2[$];  // same bytes packed 6 per word
  image_pipe_pkg::out_data_t  exp_data[$];
  image_pipe_pkg::kernel_h_t  exp_user[$];
  logic                       exp_last[$];

  int   errors     = 0;
  int   pass_count = 0;
  int   fail_count = 0;
  logic timed_out  = 1'b0;

  image_pipe_top DUT (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .s_axis_1_tvalid (s_axis_1_tvalid),
    .s_axis_1_tready (s_axis_1_tready),
    .s_axis_1_tdata  (s_axis_1_tdata),
    .s_axis_1_tkeep  (s_axis_1_tkeep),
    .s_axis_1_tlast  (s_axis_1_tlast),
    .s_axis_2_tvalid (s_axis_2_tvalid),
    .s_axis_2_tready (s_axis_2_tready),
    .s_axis_2_tdata  (s_axis_2_tdata),
    .s_axis_2_tkeep  (s_axis_2_tkeep),
    .s_axis_2_tlast  (s_axis_2_tlast),
    .m_axis_tvalid   (m_axis_tvalid),
    .m_axis_tready   (m_axis_tready),
    .m_axis_tdata    (m_axis_tdata),
    .m_axis_tuser    (m_axis_tuser),
    .m_axis_tlast    (m_axis_tlast)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD/2) aclk = ~aclk;
  end

  `include "tb_image_pipe_tasks.svh"

  // packs kept bytes in order into 6-byte words with a zero padded final word
  task automatic pack_words(input int stream);
    image_pipe_pkg::word_t      bytes[$];
    image_pipe_pkg::edge_data_t word = '0;
    if (stream == 1) bytes = pix_1;
    else bytes = pix_2;
    for (int i = 0; i < bytes.size(); i++) begin
      word[(i % EDGES)*WORD_W +: WORD_W] = bytes[i];
      if (i % EDGES == EDGES - 1 || i == bytes.size() - 1) begin
        if (stream == 1) words_1.push_back(word);
        else words_2.push_back(word);
        word = '0;
      end
    end
  endtask

  // spreads the pixel bytes over 8-lane beats with optional sparse keeps
  task automatic split_beats(input int stream, input bit sparse);
    image_pipe_pkg::word_t    bytes[$];
    image_pipe_pkg::in_data_t data;
    image_pipe_pkg::in_keep_t keep;
    int                       idx = 0;
    int                       remain;
    if (stream == 1) bytes = pix_1;
    else bytes = pix_2;
    remain = bytes.size();
    while (remain > 0) begin
      keep = sparse ? image_pipe_pkg::in_keep_t'($urandom) : '1;
      if (keep == '0) keep = 'h1;
      for (int l = IN_WORDS - 1; l >= 0; l--) begin
        if (keep[l] && $countones(keep) > remain) keep[l] = 1'b0; // short final beat
      end
      data = {$urandom, $urandom}; // dropped lanes carry junk
      for (int l = 0; l < IN_WORDS; l++) begin
        if (keep[l]) begin
          data[l*WORD_W +: WORD_W] = bytes[idx];
          idx++;
        end
      end
      remain -= $countones(keep);
      if (stream == 1) begin
        data_1_q.push_back(data);
        keep_1_q.push_back(keep);
        last_1_q.push_back(remain == 0);
      end else begin
        data_2_q.push_back(data);
        keep_2_q.push_back(keep);
        last_2_q.push_back(remain == 0);
      end
    end
  endtask

  // builds the config beat, pixel beats and expected outputs of one image
  task automatic build_image(input logic max_mode, input image_pipe_pkg::kernel_h_t kh,
                             input int n_bytes, input bit sparse);
    image_pipe_pkg::in_data_t  cfg;
    image_pipe_pkg::out_data_t beat;
    int                        n_ones;
    data_1_q.delete();
    keep_1_q.delete();
    last_1_q.delete();
    data_2_q.delete();
    keep_2_q.delete();
    last_2_q.delete();
    pix_1.delete();
    pix_2.delete();
    words_1.delete();
    words_2.delete();
    exp_data.delete();
    exp_user.delete();
    exp_last.delete();
    for (int i = 0; i < n_bytes; i++) begin
      pix_1.push_back(image_pipe_pkg::word_t'($urandom));
      if (max_mode) pix_2.push_back(image_pipe_pkg::word_t'($urandom));
    end
    cfg = {$urandom, $urandom};
    cfg[0] = max_mode;                                   // upper bits of byte 0 are noise
    cfg[WORD_W +: WORD_W] = image_pipe_pkg::word_t'(kh);
    data_1_q.push_back(cfg);
    keep_1_q.push_back(image_pipe_pkg::in_keep_t'(8'h3F));
    last_1_q.push_back(1'b0);
    split_beats(1, sparse);
    split_beats(2, sparse);
    pack_words(1);
    pack_words(2);
    n_ones = (kh == '0) ? `IP_BEATS_CONFIG_1X1 : `IP_BEATS_CONFIG_3X3;
    beat   = '1;
    for (int i = 0; i < n_ones; i++) begin
      exp_data.push_back(beat);
      exp_user.push_back(kh);
      exp_last.push_back(1'b0);
    end
    for (int i = 0; i < words_1.size(); i++) begin
      beat = {(max_mode ? words_2[i] : words_1[i]), words_1[i]};
      exp_data.push_back(beat);
      exp_user.push_back(kh);
      exp_last.push_back(i == words_1.size() - 1);
    end
  endtask

  task automatic check_idle();
    for (int c = 0; c < 8; c++) begin
      #(CLK_PERIOD/4);
      if (m_axis_tvalid) begin
        $display("unexpected extra beat on m_axis after the image ended");
        errors++;
      end
      @(negedge aclk);
    end
  endtask

  task automatic run_image(input int gap_1, input int gap_2, input int bp_pct);
    @(negedge aclk);
    fork
      drive_stream_1(gap_1);
      drive_stream_2(gap_2);
      collect_image(bp_pct);
    join
    if (!timed_out) check_idle();
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (timed_out) begin
      fail_count++;
      $display("%s: stopped by a timeout", name);
    end else if (errors == start_errors) begin
      pass_count++;
      $display("%s: passed", name);
    end else begin
      fail_count++;
      $display("%s: failed with %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic end_run();
    $display("tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    timed_out = 1'b1;
  endtask

  task automatic test_ones_1x1();
    int start = errors;
    check_last("m_axis_tvalid", 1'b0, m_axis_tvalid); // still idle after reset
    build_image(1'b0, 2'd0, 30, 1'b0);
    run_image(0, 0, 0);
    report_test("test_ones_1x1", start);
  endtask

  task automatic test_ones_3x3();
    int start = errors;
    build_image(1'b0, 2'd2, 36, 1'b0);  // full final word
    run_image(0, 0, 0);
    report_test("test_ones_3x3", start);
  endtask

  task automatic test_pass();
    int start = errors;
    build_image(1'b0, 2'd0, 47, 1'b0);
    run_image(30, 0, 0);
    build_image(1'b0, 2'd2, 20, 1'b0);  // next image with a new config
    run_image(30, 0, 0);
    report_test("test_pass", start);
  endtask

  task automatic test_max();
    int start = errors;
    build_image(1'b1, 2'd2, 42, 1'b0);
    run_image(0, 50, 0);
    report_test("test_max", start);
  endtask

  task automatic test_packing();
    int start = errors;
    build_image(1'b1, 2'd0, 53, 1'b1);
    run_image(20, 20, 0);
    report_test("test_packing", start);
  endtask

  // same stimulus and model with ready held high and then throttled
  task automatic test_backpressure();
    int start = errors;
    build_image(1'b1, 2'd2, 61, 1'b1);
    run_image(0, 0, 0);
    run_image(20, 20, 50);
    build_image(1'b0, 2'd0, 40, 1'b1);
    run_image(10, 0, 60);
    report_test("test_backpressure", start);
  endtask

  initial begin
    void'($urandom(72));
    rst_n           = 1'b0;
    s_axis_1_tvalid = 1'b0;
    s_axis_1_tdata  = '0;
    s_axis_1_tkeep  = '0;
    s_axis_1_tlast  = 1'b0;
    s_axis_2_tvalid = 1'b0;
    s_axis_2_tdata  = '0;
    s_axis_2_tkeep  = '0;
    s_axis_2_tlast  = 1'b0;
    m_axis_tready   = 1'b1;
    repeat (5) @(negedge aclk);
    rst_n = 1'b1;
    test_ones_1x1();
    if (!timed_out) test_ones_3x3();
    if (!timed_out) test_pass();
    if (!timed_out) test_max();
    if (!timed_out) test_packing();
    if (!timed_out) test_backpressure();
    end_run();
  end

endmodule
